/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module bus_soc_tb -Mdir obj_dir
	./obj_dir/Vbus_soc_tb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* hdl/bus_arbiter.sv */
`default_nettype none

module bus_arbiter (
  input  wire                  clk,
  input  wire                  rst,
  input  bus_if_pkg::rd_req_t  ifu_req_i,
  output bus_if_pkg::rd_rsp_t  ifu_rsp_o,
  input  bus_if_pkg::rd_req_t  lsu_rd_req_i,
  output bus_if_pkg::rd_rsp_t  lsu_rd_rsp_o,
  input  bus_if_pkg::wr_req_t  lsu_wr_req_i,
  output logic                 lsu_wr_done_o,
  output bus_if_pkg::dev_req_t sram_req_o,
  output bus_if_pkg::dev_req_t serial_req_o,
  output bus_if_pkg::dev_req_t clint_req_o,
  input  bus_if_pkg::dev_rsp_t sram_rsp_i,
  input  bus_if_pkg::dev_rsp_t serial_rsp_i,
  input  bus_if_pkg::dev_rsp_t clint_rsp_i
);

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT, RESP} state_t;

  state_t state_q;

  // owner and target of the access in flight
  logic is_wr_q;
  logic own_if_q;
  logic sel_serial_q;
  logic sel_clint_q;

  bus_map_pkg::addr_t addr_q;
  bus_map_pkg::data_t wdata_q;
  bus_map_pkg::strb_t strb_q;
  bus_map_pkg::data_t rdata_q;

  logic any_req;
  logic dev_done;
  logic rd_go;
  logic wr_go;
  bus_map_pkg::data_t dev_rdata;

  assign any_req = lsu_rd_req_i.valid | lsu_wr_req_i.valid | ifu_req_i.valid;

  // reply from whichever device was chosen
  assign dev_done  = sel_clint_q  ? clint_rsp_i.done  :
                     sel_serial_q ? serial_rsp_i.done : sram_rsp_i.done;
  assign dev_rdata = sel_clint_q  ? clint_rsp_i.data  :
                     sel_serial_q ? serial_rsp_i.data : sram_rsp_i.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= IDLE;
      is_wr_q      <= 1'b0;
      own_if_q     <= 1'b0;
      sel_serial_q <= 1'b0;
      sel_clint_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (any_req) begin
            state_q <= ISSUE;
          end
          // load beats store beats fetch
          if (lsu_rd_req_i.valid) begin
            is_wr_q      <= 1'b0;
            own_if_q     <= 1'b0;
            sel_serial_q <= 1'b0;
            sel_clint_q  <= (lsu_rd_req_i.addr == bus_map_pkg::RTC_LO_ADDR) ||
                            (lsu_rd_req_i.addr == bus_map_pkg::RTC_HI_ADDR);
          end else if (lsu_wr_req_i.valid) begin
            is_wr_q      <= 1'b1;
            own_if_q     <= 1'b0;
            sel_serial_q <= (lsu_wr_req_i.addr == bus_map_pkg::SERIAL_ADDR);
            sel_clint_q  <= 1'b0;
          end else if (ifu_req_i.valid) begin
            is_wr_q      <= 1'b0;
            own_if_q     <= 1'b1;
            sel_serial_q <= 1'b0;
            sel_clint_q  <= (ifu_req_i.addr == bus_map_pkg::RTC_LO_ADDR) ||
                            (ifu_req_i.addr == bus_map_pkg::RTC_HI_ADDR);
          end
        end
        ISSUE: state_q <= WAIT;
        WAIT: begin
          if (dev_done) begin
            state_q <= RESP;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // address and data of the chosen request
  always_ff @(posedge clk) begin
    if (state_q == IDLE) begin
      if (lsu_rd_req_i.valid) begin
        addr_q <= lsu_rd_req_i.addr;
      end else if (lsu_wr_req_i.valid) begin
        addr_q <= lsu_wr_req_i.addr;
      end else begin
        addr_q <= ifu_req_i.addr;
      end
      wdata_q <= lsu_wr_req_i.data;
      strb_q  <= lsu_wr_req_i.strb;
    end
    if (state_q == WAIT && dev_done) begin
      rdata_q <= dev_rdata;
    end
  end

  assign rd_go = (state_q == ISSUE) && !is_wr_q;
  assign wr_go = (state_q == ISSUE) && is_wr_q;

  // strobes, only one device sees one
  assign sram_req_o   = '{rd: rd_go && !sel_clint_q, wr: wr_go && !sel_serial_q,
                          addr: addr_q, data: wdata_q, strb: strb_q};
  assign serial_req_o = '{rd: 1'b0, wr: wr_go && sel_serial_q,
                          addr: addr_q, data: wdata_q, strb: strb_q};
  assign clint_req_o  = '{rd: rd_go && sel_clint_q, wr: 1'b0,
                          addr: addr_q, data: wdata_q, strb: strb_q};

  // reply pulse to the owner only
  assign ifu_rsp_o.valid    = (state_q == RESP) && !is_wr_q && own_if_q;
  assign ifu_rsp_o.data     = rdata_q;
  assign lsu_rd_rsp_o.valid = (state_q == RESP) && !is_wr_q && !own_if_q;
  assign lsu_rd_rsp_o.data  = rdata_q;
  assign lsu_wr_done_o      = (state_q == RESP) && is_wr_q;

endmodule

`default_nettype wire

/* hdl/bus_if_pkg.sv */
`default_nettype none

package bus_if_pkg;

  // read request from fetch or load, held until the reply
  typedef struct packed {
    logic               valid;
    bus_map_pkg::addr_t addr;
  } rd_req_t;

  // read reply, valid is a one cycle pulse
  typedef struct packed {
    logic               valid;
    bus_map_pkg::data_t data;
  } rd_rsp_t;

  // store request, held until the done pulse
  typedef struct packed {
    logic               valid;
    bus_map_pkg::addr_t addr;
    bus_map_pkg::data_t data;
    bus_map_pkg::strb_t strb;
  } wr_req_t;

  // arbiter to device, rd and wr are single cycle strobes
  typedef struct packed {
    logic               rd;
    logic               wr;
    bus_map_pkg::addr_t addr;
    bus_map_pkg::data_t data;
    bus_map_pkg::strb_t strb;
  } dev_req_t;

  // device to arbiter
  typedef struct packed {
    logic               done;
    bus_map_pkg::data_t data;
  } dev_rsp_t;

  // serial character out
  typedef struct packed {
    logic               valid;
    bus_map_pkg::byte_t data;
  } tx_t;

endpackage

`default_nettype wire

/* hdl/bus_map_pkg.sv */
`default_nettype none

package bus_map_pkg;

  // bus widths
  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = DATA_W / 8;
  localparam int BYTE_W    = 8;

  // sram geometry, word index sits above the byte offset
  localparam int MEM_WORDS   = 256;
  localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
  localparam int MEM_IDX_LSB = 2;

  // wait state sequence length
  localparam int LFSR_W = 20;

  // picks the high word of machine time
  localparam int RTC_SEL_BIT = 2;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [STRB_W-1:0]    strb_t;
  typedef logic [MEM_IDX_W-1:0] mem_idx_t;
  typedef logic [BYTE_W-1:0]    byte_t;

  // device addresses, everything else lands in the sram
  localparam addr_t SERIAL_ADDR = 32'ha000_03f8;
  localparam addr_t RTC_LO_ADDR = 32'ha000_0048;
  localparam addr_t RTC_HI_ADDR = 32'ha000_004c;

endpackage

`default_nettype wire

/* hdl/bus_soc_top.sv */
`default_nettype none

module bus_soc_top (
  input  wire                 clk,
  input  wire                 rst,
  input  bus_if_pkg::rd_req_t ifu_req_i,
  output bus_if_pkg::rd_rsp_t ifu_rsp_o,
  input  bus_if_pkg::rd_req_t lsu_rd_req_i,
  output bus_if_pkg::rd_rsp_t lsu_rd_rsp_o,
  input  bus_if_pkg::wr_req_t lsu_wr_req_i,
  output logic                lsu_wr_done_o,
  output bus_if_pkg::tx_t     tx_o
);

  bus_if_pkg::dev_req_t sram_req;
  bus_if_pkg::dev_req_t serial_req;
  bus_if_pkg::dev_req_t clint_req;
  bus_if_pkg::dev_rsp_t sram_rsp;
  bus_if_pkg::dev_rsp_t serial_rsp;
  bus_if_pkg::dev_rsp_t clint_rsp;

  bus_arbiter bus_arbiter_i (
    .clk           (clk),
    .rst           (rst),
    .ifu_req_i     (ifu_req_i),
    .ifu_rsp_o     (ifu_rsp_o),
    .lsu_rd_req_i  (lsu_rd_req_i),
    .lsu_rd_rsp_o  (lsu_rd_rsp_o),
    .lsu_wr_req_i  (lsu_wr_req_i),
    .lsu_wr_done_o (lsu_wr_done_o),
    .sram_req_o    (sram_req),
    .serial_req_o  (serial_req),
    .clint_req_o   (clint_req),
    .sram_rsp_i    (sram_rsp),
    .serial_rsp_i  (serial_rsp),
    .clint_rsp_i   (clint_rsp)
  );

  sram_mem sram_mem_i (
    .clk   (clk),
    .rst   (rst),
    .req_i (sram_req),
    .rsp_o (sram_rsp)
  );

  serial_tx serial_tx_i (
    .clk   (clk),
    .rst   (rst),
    .req_i (serial_req),
    .rsp_o (serial_rsp),
    .tx_o  (tx_o)
  );

  clint_timer clint_timer_i (
    .clk   (clk),
    .rst   (rst),
    .req_i (clint_req),
    .rsp_o (clint_rsp)
  );

endmodule

`default_nettype wire

/* hdl/clint_timer.sv */
`default_nettype none

module clint_timer (
  input  wire                  clk,
  input  wire                  rst,
  input  bus_if_pkg::dev_req_t req_i,
  output bus_if_pkg::dev_rsp_t rsp_o
);

  logic [2*bus_map_pkg::DATA_W-1:0] mtime_q;
  logic                             done_q;
  bus_map_pkg::data_t               rdata_q;

  // machine time counts every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime_q <= '0;
      done_q  <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
      done_q  <= req_i.rd;
    end
  end

  // word select from address bit 2
  always_ff @(posedge clk) begin
    if (req_i.rd) begin
      if (req_i.addr[bus_map_pkg::RTC_SEL_BIT]) begin
        rdata_q <= mtime_q[2*bus_map_pkg::DATA_W-1:bus_map_pkg::DATA_W];
      end else begin
        rdata_q <= mtime_q[bus_map_pkg::DATA_W-1:0];
      end
    end
  end

  assign rsp_o.done = done_q;
  assign rsp_o.data = rdata_q;

endmodule

`default_nettype wire

/* hdl/serial_tx.sv */
`default_nettype none

module serial_tx (
  input  wire                  clk,
  input  wire                  rst,
  input  bus_if_pkg::dev_req_t req_i,
  output bus_if_pkg::dev_rsp_t rsp_o,
  output bus_if_pkg::tx_t      tx_o
);

  logic               pend_q;
  bus_map_pkg::byte_t char_q;

  // one cycle pending flag after each write strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= 1'b0;
    end else begin
      pend_q <= req_i.wr;
    end
  end

  // low byte of the store is the character
  always_ff @(posedge clk) begin
    if (req_i.wr) begin
      char_q <= req_i.data[bus_map_pkg::BYTE_W-1:0];
    end
  end

  assign tx_o.valid = pend_q;
  assign tx_o.data  = char_q;

  // write only, no read data
  assign rsp_o.done = pend_q;
  assign rsp_o.data = '0;

endmodule

`default_nettype wire

/* hdl/sram_mem.sv */
`default_nettype none

module sram_mem (
  input  wire                  clk,
  input  wire                  rst,
  input  bus_if_pkg::dev_req_t req_i,
  output bus_if_pkg::dev_rsp_t rsp_o
);

  bus_map_pkg::data_t mem [bus_map_pkg::MEM_WORDS];

  logic [bus_map_pkg::LFSR_W-1:0] lfsr_q;
  logic [1:0]                     wait_q;
  logic                           busy_q;
  bus_map_pkg::data_t             rdata_q;
  bus_map_pkg::mem_idx_t          idx;

  // only the index bits of the address matter
  assign idx = req_i.addr[bus_map_pkg::MEM_IDX_LSB +: bus_map_pkg::MEM_IDX_W];

  // free running sequence for back-pressure
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr_q <= 1;
    end else begin
      lfsr_q <= {lfsr_q[bus_map_pkg::LFSR_W-2:0],
                 lfsr_q[bus_map_pkg::LFSR_W-1] ^ lfsr_q[bus_map_pkg::LFSR_W-2]};
    end
  end

  // wait count loaded at the strobe, done when it hits zero
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      wait_q <= '0;
    end else if (req_i.rd || req_i.wr) begin
      busy_q <= 1'b1;
      wait_q <= lfsr_q[1:0];
    end else if (busy_q) begin
      if (wait_q == '0) begin
        busy_q <= 1'b0;
      end else begin
        wait_q <= wait_q - 2'd1;
      end
    end
  end

  // byte lane writes, read data captured at the strobe
  always_ff @(posedge clk) begin
    if (req_i.wr) begin
      for (int b = 0; b < bus_map_pkg::STRB_W; b++) begin
        if (req_i.strb[b]) begin
          mem[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
        end
      end
    end
    if (req_i.rd) begin
      rdata_q <= mem[idx];
    end
  end

  assign rsp_o.done = busy_q && (wait_q == '0);
  assign rsp_o.data = rdata_q;

endmodule

`default_nettype wire

/* src.f */
hdl/bus_map_pkg.sv
hdl/bus_if_pkg.sv
hdl/bus_arbiter.sv
hdl/sram_mem.sv
hdl/serial_tx.sv
hdl/clint_timer.sv
hdl/bus_soc_top.sv
verification/bus_soc_tb.sv

/* verification/bus_soc_tb.sv */
`default_nettype none

module bus_soc_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS   = 14;
  localparam int WAIT_LIMIT  = 16;
  localparam int CYCLE_LIMIT = NUM_TESTS * 10 + 20;

  typedef enum {OP_FETCH, OP_LOAD, OP_STORE, OP_BOTH} op_e;
  typedef enum {EXP_DONE, EXP_TX, EXP_MEM, EXP_ZERO, EXP_RISE} kind_e;

  // one row of stimulus with a separate fetch address
  typedef struct {
    op_e                op;
    bus_map_pkg::addr_t addr;
    bus_map_pkg::addr_t fetch_addr;
    bus_map_pkg::data_t wdata;
    bus_map_pkg::strb_t strb;
    kind_e              kind;
  } entry_t;

  logic                clk;
  logic                rst;
  bus_if_pkg::rd_req_t ifu_req;
  bus_if_pkg::rd_rsp_t ifu_rsp;
  bus_if_pkg::rd_req_t lsu_rd_req;
  bus_if_pkg::rd_rsp_t lsu_rd_rsp;
  bus_if_pkg::wr_req_t lsu_wr_req;
  logic                lsu_wr_done;
  bus_if_pkg::tx_t     tx;

  entry_t             tests [NUM_TESTS];
  bus_map_pkg::data_t shadow [bus_map_pkg::MEM_WORDS];
  int                 n_entries;
  int                 errors;
  int                 passed;
  int                 cycle_cnt;
  int                 seed_val;
  logic               have_lo;
  bus_map_pkg::data_t last_lo;

  bus_soc_top bus_soc_top_i (
    .clk           (clk),
    .rst           (rst),
    .ifu_req_i     (ifu_req),
    .ifu_rsp_o     (ifu_rsp),
    .lsu_rd_req_i  (lsu_rd_req),
    .lsu_rd_rsp_o  (lsu_rd_rsp),
    .lsu_wr_req_i  (lsu_wr_req),
    .lsu_wr_done_o (lsu_wr_done),
    .tx_o          (tx)
  );

  always #50 clk = ~clk;

  task automatic check_data(input string name, input bus_map_pkg::data_t exp,
                            input bus_map_pkg::data_t act);
    if (exp !== act) begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input bus_map_pkg::byte_t exp,
                            input bus_map_pkg::byte_t act);
    if (exp !== act) begin
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_done(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // sram word index sits in address bits 9 to 2
  function automatic bus_map_pkg::addr_t word_addr(input bus_map_pkg::mem_idx_t idx);
    return {22'b0, idx, 2'b00};
  endfunction

  task automatic add_entry(input op_e op, input bus_map_pkg::addr_t addr,
                           input bus_map_pkg::addr_t fetch_addr,
                           input bus_map_pkg::data_t wdata,
                           input bus_map_pkg::strb_t strb, input kind_e kind);
    tests[n_entries] = '{op, addr, fetch_addr, wdata, strb, kind};
    n_entries++;
  endtask

  task automatic build_tests();
    bus_map_pkg::data_t r;
    bus_map_pkg::addr_t a_addr;
    bus_map_pkg::addr_t b_addr;
    bus_map_pkg::addr_t c_addr;
    // three distinct words
    // c shares its index with the serial register address
    r = $urandom;
    a_addr = word_addr({1'b0, r[6:0]});
    r = $urandom;
    b_addr = word_addr({2'b10, r[5:0]});
    c_addr = word_addr(8'hfe);
    add_entry(OP_STORE, a_addr, '0, $urandom, 4'hf, EXP_DONE);
    add_entry(OP_LOAD, a_addr, '0, '0, '0, EXP_MEM);
    add_entry(OP_FETCH, '0, a_addr, '0, '0, EXP_MEM);
    add_entry(OP_STORE, b_addr, '0, $urandom, 4'hf, EXP_DONE);
    add_entry(OP_STORE, b_addr, '0, $urandom, 4'b0101, EXP_DONE);
    add_entry(OP_STORE, b_addr, '0, $urandom, 4'b1000, EXP_DONE);
    add_entry(OP_LOAD, b_addr, '0, '0, '0, EXP_MEM);
    add_entry(OP_STORE, c_addr, '0, $urandom, 4'hf, EXP_DONE);
    add_entry(OP_STORE, bus_map_pkg::SERIAL_ADDR, '0, $urandom, 4'hf, EXP_TX);
    add_entry(OP_LOAD, c_addr, '0, '0, '0, EXP_MEM);
    add_entry(OP_LOAD, bus_map_pkg::RTC_HI_ADDR, '0, '0, '0, EXP_ZERO);
    add_entry(OP_LOAD, bus_map_pkg::RTC_LO_ADDR, '0, '0, '0, EXP_RISE);
    add_entry(OP_LOAD, bus_map_pkg::RTC_LO_ADDR, '0, '0, '0, EXP_RISE);
    add_entry(OP_BOTH, b_addr, a_addr, '0, '0, EXP_MEM);
  endtask

  task automatic apply_entry(input int n);
    entry_t             e;
    bus_map_pkg::data_t rd_word;
    bus_map_pkg::data_t if_word;
    bus_map_pkg::byte_t tx_byte;
    logic               rd_pend;
    logic               if_pend;
    logic               wr_pend;
    int                 rd_at;
    int                 if_at;
    int                 tx_seen;
    int                 waited;
    int                 err_before;
    e = tests[n];
    err_before = errors;
    rd_pend = (e.op == OP_LOAD) || (e.op == OP_BOTH);
    if_pend = (e.op == OP_FETCH) || (e.op == OP_BOTH);
    wr_pend = (e.op == OP_STORE);
    rd_word = '0;
    if_word = '0;
    tx_byte = '0;
    rd_at = 0;
    if_at = 0;
    tx_seen = 0;
    waited = 0;
    @(posedge clk);
    if (rd_pend) lsu_rd_req <= '{valid: 1'b1, addr: e.addr};
    if (if_pend) ifu_req <= '{valid: 1'b1, addr: e.fetch_addr};
    if (wr_pend) lsu_wr_req <= '{valid: 1'b1, addr: e.addr, data: e.wdata, strb: e.strb};
    while ((rd_pend || if_pend || wr_pend) && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
      if (tx.valid) begin
        tx_seen++;
        tx_byte = tx.data;
      end
      if (lsu_rd_rsp.valid && rd_pend) begin
        rd_word = lsu_rd_rsp.data;
        rd_at = waited;
        rd_pend = 1'b0;
      end
      if (ifu_rsp.valid && if_pend) begin
        if_word = ifu_rsp.data;
        if_at = waited;
        if_pend = 1'b0;
      end
      if (lsu_wr_done && wr_pend) wr_pend = 1'b0;
      // requester drops valid at the edge after its pulse
      @(posedge clk);
      if (!rd_pend) lsu_rd_req.valid <= 1'b0;
      if (!if_pend) ifu_req.valid <= 1'b0;
      if (!wr_pend) lsu_wr_req.valid <= 1'b0;
    end
    if (rd_pend || if_pend || wr_pend) begin
      $display("test %0d got no reply pulse within %0d cycles", n, WAIT_LIMIT);
      errors++;
      lsu_rd_req.valid <= 1'b0;
      ifu_req.valid <= 1'b0;
      lsu_wr_req.valid <= 1'b0;
    end
    case (e.kind)
      EXP_DONE: begin
        for (int b = 0; b < 4; b++) begin
          if (e.strb[b]) shadow[e.addr[9:2]][b*8 +: 8] = e.wdata[b*8 +: 8];
        end
        check_done("tx_o.valid", 1'b0, tx_seen != 0);
      end
      EXP_TX: begin
        check_done("tx_o.valid", 1'b1, tx_seen != 0);
        if (tx_seen > 1) begin
          $display("test %0d saw %0d tx pulses for one store", n, tx_seen);
          errors++;
        end
        check_byte("tx_o.data", e.wdata[7:0], tx_byte);
      end
      EXP_MEM: begin
        if (e.op != OP_FETCH) check_data("lsu_rd_rsp_o.data", shadow[e.addr[9:2]], rd_word);
        if (e.op != OP_LOAD) check_data("ifu_rsp_o.data", shadow[e.fetch_addr[9:2]], if_word);
        if (e.op == OP_BOTH && rd_at != 0 && if_at != 0 && rd_at >= if_at) begin
          $display("test %0d fetch reply arrived before the load reply", n);
          errors++;
        end
      end
      EXP_ZERO: check_data("lsu_rd_rsp_o.data", '0, rd_word);
      default: begin
        // machine time must move forward between two reads
        if (have_lo && ((rd_word > last_lo) !== 1'b1)) begin
          $display("FAIL %0t lsu_rd_rsp_o.data expected above %h actual %h",
                   $time, last_lo, rd_word);
          errors++;
        end
        have_lo = 1'b1;
        last_lo = rd_word;
      end
    endcase
    if (errors == err_before) begin
      passed++;
      $display("test %0d ok (%s)", n, e.op.name());
    end else begin
      $display("test %0d failed (%s)", n, e.op.name());
    end
  endtask

  // no pulse may appear without a pending request, even in reset
  always @(negedge clk) begin
    if (ifu_rsp.valid && !ifu_req.valid) begin
      $display("fetch reply pulse at %0t with no fetch pending", $time);
      errors++;
    end
    if (lsu_rd_rsp.valid && !lsu_rd_req.valid) begin
      $display("load reply pulse at %0t with no load pending", $time);
      errors++;
    end
    if (lsu_wr_done && !lsu_wr_req.valid) begin
      $display("store done pulse at %0t with no store pending", $time);
      errors++;
    end
    if (tx.valid && !(lsu_wr_req.valid && lsu_wr_req.addr == bus_map_pkg::SERIAL_ADDR)) begin
      $display("tx pulse at %0t with no serial store pending", $time);
      errors++;
    end
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, run still busy after %0d cycles", cycle_cnt);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    ifu_req = '0;
    lsu_rd_req = '0;
    lsu_wr_req = '0;
    errors = 0;
    passed = 0;
    n_entries = 0;
    have_lo = 1'b0;
    last_lo = '0;
    seed_val = $urandom(32'h48869e33);
    build_tests();
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int n = 0; n < n_entries; n++) begin
      apply_entry(n);
    end
    repeat (2) @(posedge clk);
    $display("%0d of %0d tests passed, %0d errors", passed, n_entries, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
